// ==== source/pwo_params.svh ====
`ifndef PWO_PARAMS_SVH
`define PWO_PARAMS_SVH

// ==================================================
// ML-DSA pointwise engine constants
// ==================================================

// Modulus q = 2^23 - 2^13 + 1
`define PWO_Q       23'd8380417

// Coefficient and memory word layout
`define PWO_COEFF_W 23
`define PWO_LANE_W  24
`define PWO_LANES   4
`define PWO_ADDR_W  15
`define PWO_WORDS   64

// Read request to write of the same word
`define PWO_WR_LAT  5

`endif

// ==== source/pwo_pkg.sv ====
`default_nettype none

`include "pwo_params.svh"

package pwo_pkg;

    // ==================================================
    // Data types
    // ==================================================

    typedef logic [`PWO_COEFF_W-1:0]             coeff_t;
    typedef logic [`PWO_LANES*`PWO_LANE_W-1:0]   word_t;
    typedef logic [`PWO_ADDR_W-1:0]              addr_t;
    typedef logic [$clog2(`PWO_WORDS)-1:0]       idx_t;

    // Pointwise operation selected for a run
    typedef enum logic [1:0] {
        PWO_PWM = 2'd0,
        PWO_PWA = 2'd1,
        PWO_PWS = 2'd2
    } pwo_mode_e;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/pwo_cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwo_cfg_regs (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                zeroize_i,
    input  wire                load_i,
    input  wire pwo_pkg::pwo_mode_e mode_i,
    input  wire pwo_pkg::addr_t     base_a_i,
    input  wire pwo_pkg::addr_t     base_b_i,
    input  wire pwo_pkg::addr_t     base_c_i,
    input  wire                accumulate_i,
    output pwo_pkg::pwo_mode_e mode_o,
    output pwo_pkg::addr_t     base_a_o,
    output pwo_pkg::addr_t     base_b_o,
    output pwo_pkg::addr_t     base_c_o,
    output logic               acc_en_o
);
    import pwo_pkg::*;

    // Configuration is frozen at start and held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_o   <= PWO_PWM;
            base_a_o <= '0;
            base_b_o <= '0;
            base_c_o <= '0;
            acc_en_o <= 1'b0;
        end else if (zeroize_i) begin
            mode_o   <= PWO_PWM;
            base_a_o <= '0;
            base_b_o <= '0;
            base_c_o <= '0;
            acc_en_o <= 1'b0;
        end else if (load_i) begin
            mode_o   <= mode_i;
            base_a_o <= base_a_i;
            base_b_o <= base_b_i;
            base_c_o <= base_c_i;
            // Accumulate only makes sense for multiply
            acc_en_o <= accumulate_i && (mode_i == PWO_PWM);
        end
    end

endmodule

`default_nettype wire

// ==== source/pwo_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_ctrl (
    input  wire            clk,
    input  wire            reset_n,
    input  wire            zeroize_i,
    input  wire            start_i,
    input  wire            sampler_valid_i,
    input  wire            acc_en_i,
    input  wire pwo_pkg::addr_t base_a_i,
    input  wire pwo_pkg::addr_t base_b_i,
    input  wire pwo_pkg::addr_t base_c_i,
    output logic           load_o,
    output logic           rd_en_a_o,
    output logic           rd_en_b_o,
    output logic           rd_en_c_o,
    output pwo_pkg::addr_t rd_addr_a_o,
    output pwo_pkg::addr_t rd_addr_b_o,
    output pwo_pkg::addr_t rd_addr_c_o,
    output logic           word_valid_o,
    output logic           wr_en_o,
    output pwo_pkg::addr_t wr_addr_o,
    output logic           busy_o,
    output logic           done_o
);
    import pwo_pkg::*;

    ctrl_state_e             state_q;
    ctrl_state_e             state_d;
    idx_t                    issue_idx_q;
    logic                    issue;
    logic                    last_issue;
    logic                    last_write;
    logic                    done_q;
    // In-flight words, oldest at the top
    logic [`PWO_WR_LAT-1:0]  vld_q;
    idx_t                    idx_pipe_q [`PWO_WR_LAT];

    // ==================================================
    // Issue side
    // ==================================================

    assign load_o     = start_i && (state_q == IDLE);
    // The sampler strobe throttles every read of the run
    assign issue      = (state_q == ISSUE) && sampler_valid_i;
    assign last_issue = issue && (issue_idx_q == idx_t'(`PWO_WORDS - 1));
    // Only the youngest word is left once issue is over
    assign last_write = (state_q == DRAIN) && vld_q[`PWO_WR_LAT-1]
                        && (vld_q[`PWO_WR_LAT-2:0] == '0);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (load_o) state_d = ISSUE;
            ISSUE:   if (last_issue) state_d = DRAIN;
            DRAIN:   if (last_write) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= IDLE;
            issue_idx_q <= '0;
            vld_q       <= '0;
            done_q      <= 1'b0;
        end else if (zeroize_i) begin
            state_q     <= IDLE;
            issue_idx_q <= '0;
            vld_q       <= '0;
            done_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= last_write;
            vld_q   <= {vld_q[`PWO_WR_LAT-2:0], issue};
            if (load_o) begin
                issue_idx_q <= '0;
            end else if (issue) begin
                issue_idx_q <= issue_idx_q + idx_t'(1);
            end
        end
    end

    // Word index travels alongside its valid bit
    always_ff @(posedge clk) begin
        idx_pipe_q[0] <= issue_idx_q;
        for (int k = 1; k < `PWO_WR_LAT; k++) begin
            idx_pipe_q[k] <= idx_pipe_q[k-1];
        end
    end

    // ==================================================
    // Port outputs
    // ==================================================

    assign rd_en_a_o    = issue;
    assign rd_en_b_o    = issue;
    assign rd_en_c_o    = issue && acc_en_i;
    assign rd_addr_a_o  = base_a_i + addr_t'(issue_idx_q);
    assign rd_addr_b_o  = base_b_i + addr_t'(issue_idx_q);
    assign rd_addr_c_o  = base_c_i + addr_t'(issue_idx_q);

    // Read data returns one cycle after the request
    assign word_valid_o = vld_q[0];
    assign wr_en_o      = vld_q[`PWO_WR_LAT-1];
    assign wr_addr_o    = base_c_i + addr_t'(idx_pipe_q[`PWO_WR_LAT-1]);

    assign busy_o       = (state_q != IDLE);
    assign done_o       = done_q;

endmodule

`default_nettype wire

// ==== source/pwo_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_lane (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                zeroize_i,
    input  wire pwo_pkg::pwo_mode_e mode_i,
    input  wire                acc_en_i,
    input  wire pwo_pkg::coeff_t    a_i,
    input  wire pwo_pkg::coeff_t    b_i,
    input  wire pwo_pkg::coeff_t    c_i,
    output pwo_pkg::coeff_t    res_o
);
    import pwo_pkg::*;

    logic [2*`PWO_COEFF_W-1:0] s1_d, s1_q;
    logic [2*`PWO_COEFF_W-1:0] fold_r;
    logic [`PWO_COEFF_W:0]     sum, sum_m, diff, diff_p;
    logic [`PWO_COEFF_W:0]     s2_q, red_m, acc_s, acc_m;
    coeff_t                    c1_q, c2_q, red, acc_r, res_d;

    // 2^23 folds to 2^13 - 1 modulo q
    function automatic logic [2*`PWO_COEFF_W-1:0] fold(input logic [2*`PWO_COEFF_W-1:0] x);
        logic [2*`PWO_COEFF_W-1:0] hi;
        logic [2*`PWO_COEFF_W-1:0] lo;
        hi = x >> `PWO_COEFF_W;
        lo = {{`PWO_COEFF_W{1'b0}}, x[`PWO_COEFF_W-1:0]};
        return lo + (hi << 13) - hi;
    endfunction

    // Stage one, product or reduced sum and difference
    always_comb begin
        sum    = {1'b0, a_i} + {1'b0, b_i};
        sum_m  = sum - {1'b0, `PWO_Q};
        diff   = {1'b0, a_i} - {1'b0, b_i};
        diff_p = diff + {1'b0, `PWO_Q};
        unique case (mode_i)
            PWO_PWM: s1_d = {{`PWO_COEFF_W{1'b0}}, a_i} * {{`PWO_COEFF_W{1'b0}}, b_i};
            PWO_PWA: s1_d = {{`PWO_COEFF_W{1'b0}},
                             sum_m[`PWO_COEFF_W] ? sum[`PWO_COEFF_W-1:0]
                                                 : sum_m[`PWO_COEFF_W-1:0]};
            PWO_PWS: s1_d = {{`PWO_COEFF_W{1'b0}},
                             diff[`PWO_COEFF_W] ? diff_p[`PWO_COEFF_W-1:0]
                                                : diff[`PWO_COEFF_W-1:0]};
            default: s1_d = '0;
        endcase
    end

    // Stage two, three folds bring the value below 2q
    assign fold_r = fold(fold(fold(s1_q)));

    // Stage three, final correction and optional accumulate
    always_comb begin
        red_m = s2_q - {1'b0, `PWO_Q};
        red   = red_m[`PWO_COEFF_W] ? s2_q[`PWO_COEFF_W-1:0] : red_m[`PWO_COEFF_W-1:0];
        acc_s = {1'b0, red} + {1'b0, c2_q};
        acc_m = acc_s - {1'b0, `PWO_Q};
        acc_r = acc_m[`PWO_COEFF_W] ? acc_s[`PWO_COEFF_W-1:0] : acc_m[`PWO_COEFF_W-1:0];
        res_d = acc_en_i ? acc_r : red;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_q  <= '0;
            s2_q  <= '0;
            c1_q  <= '0;
            c2_q  <= '0;
            res_o <= '0;
        end else if (zeroize_i) begin
            s1_q  <= '0;
            s2_q  <= '0;
            c1_q  <= '0;
            c2_q  <= '0;
            res_o <= '0;
        end else begin
            s1_q  <= s1_d;
            c1_q  <= c_i;
            s2_q  <= fold_r[`PWO_COEFF_W:0];
            c2_q  <= c1_q;
            res_o <= res_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/pwo_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_datapath (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                zeroize_i,
    input  wire                valid_i,
    input  wire pwo_pkg::pwo_mode_e mode_i,
    input  wire                acc_en_i,
    input  wire pwo_pkg::word_t     rd_data_a_i,
    input  wire pwo_pkg::word_t     rd_data_b_i,
    input  wire pwo_pkg::word_t     rd_data_c_i,
    output pwo_pkg::word_t     wr_data_o
);
    import pwo_pkg::*;

    word_t  a_q, b_q, c_q;
    coeff_t lane_res [`PWO_LANES];

    // Capture the returned words, wiped on zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else if (zeroize_i) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else if (valid_i) begin
            a_q <= rd_data_a_i;
            b_q <= rd_data_b_i;
            c_q <= rd_data_c_i;
        end
    end

    // ==================================================
    // Coefficient lanes
    // ==================================================

    for (genvar g = 0; g < `PWO_LANES; g++) begin : g_lane
        pwo_lane lane_i (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode_i),
            .acc_en_i  (acc_en_i),
            .a_i       (a_q[g*`PWO_LANE_W +: `PWO_COEFF_W]),
            .b_i       (b_q[g*`PWO_LANE_W +: `PWO_COEFF_W]),
            .c_i       (c_q[g*`PWO_LANE_W +: `PWO_COEFF_W]),
            .res_o     (lane_res[g])
        );

        // Top bit of every lane stays zero
        assign wr_data_o[g*`PWO_LANE_W +: `PWO_LANE_W] = {1'b0, lane_res[g]};
    end

endmodule

`default_nettype wire

// ==== source/pwo_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwo_top (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                zeroize_i,
    input  wire                pwo_enable_i,
    input  wire                accumulate_i,
    input  wire                sampler_valid_i,
    input  wire pwo_pkg::pwo_mode_e mode_i,
    input  wire pwo_pkg::addr_t     base_a_i,
    input  wire pwo_pkg::addr_t     base_b_i,
    input  wire pwo_pkg::addr_t     base_c_i,
    input  wire pwo_pkg::word_t     rd_data_a_i,
    input  wire pwo_pkg::word_t     rd_data_b_i,
    input  wire pwo_pkg::word_t     rd_data_c_i,
    output logic               rd_en_a_o,
    output logic               rd_en_b_o,
    output logic               rd_en_c_o,
    output pwo_pkg::addr_t     rd_addr_a_o,
    output pwo_pkg::addr_t     rd_addr_b_o,
    output pwo_pkg::addr_t     rd_addr_c_o,
    output logic               wr_en_o,
    output pwo_pkg::addr_t     wr_addr_o,
    output pwo_pkg::word_t     wr_data_o,
    output logic               busy_o,
    output logic               done_o
);
    import pwo_pkg::*;

    logic      load;
    logic      word_valid;
    logic      acc_en;
    pwo_mode_e cfg_mode;
    addr_t     cfg_base_a, cfg_base_b, cfg_base_c;

    // Run configuration
    pwo_cfg_regs cfg_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .load_i       (load),
        .mode_i       (mode_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .accumulate_i (accumulate_i),
        .mode_o       (cfg_mode),
        .base_a_o     (cfg_base_a),
        .base_b_o     (cfg_base_b),
        .base_c_o     (cfg_base_c),
        .acc_en_o     (acc_en)
    );

    // Address sequencer and write timing
    pwo_ctrl ctrl_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .start_i         (pwo_enable_i),
        .sampler_valid_i (sampler_valid_i),
        .acc_en_i        (acc_en),
        .base_a_i        (cfg_base_a),
        .base_b_i        (cfg_base_b),
        .base_c_i        (cfg_base_c),
        .load_o          (load),
        .rd_en_a_o       (rd_en_a_o),
        .rd_en_b_o       (rd_en_b_o),
        .rd_en_c_o       (rd_en_c_o),
        .rd_addr_a_o     (rd_addr_a_o),
        .rd_addr_b_o     (rd_addr_b_o),
        .rd_addr_c_o     (rd_addr_c_o),
        .word_valid_o    (word_valid),
        .wr_en_o         (wr_en_o),
        .wr_addr_o       (wr_addr_o),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    pwo_datapath datapath_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .valid_i     (word_valid),
        .mode_i      (cfg_mode),
        .acc_en_i    (acc_en),
        .rd_data_a_i (rd_data_a_i),
        .rd_data_b_i (rd_data_b_i),
        .rd_data_c_i (rd_data_c_i),
        .wr_data_o   (wr_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/pwo_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_checker (
    input wire                     clk,
    input wire                     reset_n,
    input wire                     zeroize_i,
    input wire                     arm_i,
    input wire pwo_pkg::pwo_mode_e mode_i,
    input wire                     acc_i,
    input wire pwo_pkg::addr_t     base_a_i,
    input wire pwo_pkg::addr_t     base_b_i,
    input wire pwo_pkg::addr_t     base_c_i,
    input wire                     rd_en_a_i,
    input wire                     rd_en_b_i,
    input wire                     rd_en_c_i,
    input wire pwo_pkg::addr_t     rd_addr_a_i,
    input wire                     wr_en_i,
    input wire pwo_pkg::addr_t     wr_addr_i,
    input wire pwo_pkg::word_t     wr_data_i,
    input wire                     done_i
);
    import pwo_pkg::*;

    word_t exp_word [`PWO_WORDS];
    int    rd_cyc [`PWO_WORDS];
    bit    written [`PWO_WORDS];
    bit    armed;
    bit    run_acc;
    int    cyc;
    int    wr_cnt;
    int    err_cnt = 0;
    addr_t run_a;
    addr_t run_c;

    // Expected lane from the pointwise rules, mod q
    function automatic coeff_t ref_lane(input pwo_mode_e m, input bit acc,
                                        input longint a, input longint b, input longint c);
        longint q;
        longint r;
        q = `PWO_Q;
        case (m)
            PWO_PWA: r = (a + b) % q;
            PWO_PWS: r = (a - b + q) % q;
            default: r = (a * b + (acc ? c : 0)) % q;
        endcase
        return coeff_t'(r);
    endfunction

    task automatic flag(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_cnt++;
    endtask

    always @(posedge clk or negedge reset_n) begin
        int idx;
        if (!reset_n) begin
            armed = 0;
            cyc   = 0;
        end else begin
            cyc++;
            if (zeroize_i) begin
                armed = 0;
            end else if (arm_i) begin
                // Snapshot of the operands as they stand before the run
                for (int k = 0; k < `PWO_WORDS; k++) begin
                    exp_word[k] = '0;
                    written[k]  = 0;
                    for (int l = 0; l < `PWO_LANES; l++) begin
                        exp_word[k][l*`PWO_LANE_W +: `PWO_COEFF_W] = ref_lane(mode_i, acc_i,
                            pwo_tb.mem_a[addr_t'(base_a_i + k)][l*`PWO_LANE_W +: `PWO_COEFF_W],
                            pwo_tb.mem_b[addr_t'(base_b_i + k)][l*`PWO_LANE_W +: `PWO_COEFF_W],
                            pwo_tb.mem_c[addr_t'(base_c_i + k)][l*`PWO_LANE_W +: `PWO_COEFF_W]);
                    end
                end
                // Port c is read only for multiply with accumulate
                run_acc = acc_i && (mode_i == PWO_PWM);
                run_a   = base_a_i;
                run_c   = base_c_i;
                wr_cnt  = 0;
                armed   = 1;
            end else if (armed) begin
                if (rd_en_b_i !== rd_en_a_i)
                    flag("read enable of port b out of step with port a");
                if (rd_en_c_i !== (rd_en_a_i && run_acc))
                    flag($sformatf("read enable of port c is %b with accumulate %0d",
                                   rd_en_c_i, run_acc));
                if (rd_en_a_i) begin
                    idx = int'(addr_t'(rd_addr_a_i - run_a));
                    if (idx < `PWO_WORDS) rd_cyc[idx] = cyc;
                end
                if (wr_en_i) begin
                    idx = int'(addr_t'(wr_addr_i - run_c));
                    wr_cnt++;
                    if (idx >= `PWO_WORDS) begin
                        flag($sformatf("write to 0x%0h outside the result block", wr_addr_i));
                    end else begin
                        if (written[idx]) flag($sformatf("word %0d written twice", idx));
                        if (cyc - rd_cyc[idx] != `PWO_WR_LAT)
                            flag($sformatf("word %0d written %0d cycles after its read",
                                           idx, cyc - rd_cyc[idx]));
                        if (wr_data_i !== exp_word[idx])
                            flag($sformatf("word %0d got %h expected %h",
                                           idx, wr_data_i, exp_word[idx]));
                        written[idx] = 1;
                    end
                end
                if (done_i) begin
                    if (wr_cnt != `PWO_WORDS) flag($sformatf("run wrote %0d words", wr_cnt));
                    armed = 0;
                end
            end else if (wr_en_i) begin
                flag($sformatf("write to 0x%0h outside any run", wr_addr_i));
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/pwo_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_assert (
    input wire                 clk,
    input wire                 reset_n,
    input wire                 zeroize_i,
    input wire                 start_i,
    input wire                 busy_o,
    input wire                 done_o,
    input wire                 rd_en_a_o,
    input wire                 rd_en_c_o,
    input wire                 wr_en_o,
    input wire pwo_pkg::addr_t base_a_i,
    input wire pwo_pkg::addr_t base_c_i,
    input wire pwo_pkg::addr_t rd_addr_a_o,
    input wire pwo_pkg::addr_t wr_addr_o
);
    import pwo_pkg::*;

    addr_t rd_off;
    addr_t wr_off;

    // Word index as seen on the read and write side
    assign rd_off = rd_addr_a_o - base_a_i;
    assign wr_off = wr_addr_o - base_c_i;

    a_rd_to_wr: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        rd_en_a_o |-> ##`PWO_WR_LAT (wr_en_o && wr_off == $past(rd_off, `PWO_WR_LAT)))
        else $error("write missing or misplaced after read request");

    a_wr_has_rd: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        wr_en_o |-> $past(rd_en_a_o, `PWO_WR_LAT))
        else $error("write without a matching read request");

    a_done: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        done_o |-> !busy_o ##1 !done_o)
        else $error("done is not a single pulse at the end of busy");

    a_start: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        start_i && !busy_o |=> busy_o)
        else $error("busy did not follow an accepted start");

    a_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !busy_o && !done_o && !rd_en_a_o && !rd_en_c_o && !wr_en_o)
        else $error("activity after zeroize");

endmodule

`default_nettype wire

// ==== dv/pwo_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pwo_params.svh"

module pwo_tb;
    import pwo_pkg::*;

    localparam int     PERIOD      = 40;
    localparam int     WATCHDOG_NS = (6 * `PWO_WORDS * 8 + 2000) * PERIOD;
    localparam coeff_t QM1         = coeff_t'(`PWO_Q - 1);

    logic      clk, reset_n, zeroize, pwo_enable, accumulate, sampler_valid, arm;
    pwo_mode_e mode;
    addr_t     base_a, base_b, base_c, rd_addr_a, rd_addr_b, rd_addr_c, wr_addr;
    word_t     rd_data_a, rd_data_b, rd_data_c, wr_data;
    logic      rd_en_a, rd_en_b, rd_en_c, wr_en, busy, done;
    word_t     mem_a [1 << `PWO_ADDR_W];
    word_t     mem_b [1 << `PWO_ADDR_W];
    word_t     mem_c [1 << `PWO_ADDR_W];
    int        tb_err = 0;
    int        tests_ok = 0;
    int        tests_bad = 0;
    int        e0;

    pwo_top dut_i (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .pwo_enable_i(pwo_enable),
        .accumulate_i(accumulate), .sampler_valid_i(sampler_valid), .mode_i(mode),
        .base_a_i(base_a), .base_b_i(base_b), .base_c_i(base_c),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b), .rd_data_c_i(rd_data_c),
        .rd_en_a_o(rd_en_a), .rd_en_b_o(rd_en_b), .rd_en_c_o(rd_en_c),
        .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b), .rd_addr_c_o(rd_addr_c),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .busy_o(busy), .done_o(done)
    );

    pwo_checker chk_i (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .arm_i(arm), .mode_i(mode),
        .acc_i(accumulate), .base_a_i(base_a), .base_b_i(base_b),
        .base_c_i(base_c), .rd_en_a_i(rd_en_a), .rd_en_b_i(rd_en_b), .rd_en_c_i(rd_en_c),
        .rd_addr_a_i(rd_addr_a), .wr_en_i(wr_en),
        .wr_addr_i(wr_addr), .wr_data_i(wr_data), .done_i(done)
    );

    bind pwo_ctrl pwo_assert assert_i (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .start_i(start_i),
        .busy_o(busy_o), .done_o(done_o), .rd_en_a_o(rd_en_a_o),
        .rd_en_c_o(rd_en_c_o), .wr_en_o(wr_en_o), .base_a_i(base_a_i), .base_c_i(base_c_i),
        .rd_addr_a_o(rd_addr_a_o), .wr_addr_o(wr_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Memories answer one cycle after the read enable
    always @(posedge clk) begin
        if (rd_en_a) rd_data_a <= mem_a[rd_addr_a];
        if (rd_en_b) rd_data_b <= mem_b[rd_addr_b];
        if (rd_en_c) rd_data_c <= mem_c[rd_addr_c];
        if (wr_en) mem_c[wr_addr] <= wr_data;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation hung: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int total_errs();
        return tb_err + chk_i.err_cnt;
    endfunction

    task automatic flag(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        tb_err++;
    endtask

    function automatic coeff_t rand_coeff();
        int unsigned r;
        r = $urandom % 8;
        if (r == 0) return '0;
        if (r == 1) return QM1;
        return coeff_t'($urandom % `PWO_Q);
    endfunction

    // Pairs that wrap the sum up and the difference down
    task automatic fill_region(input bit edge_pairs, input addr_t ba, input addr_t bb,
                               input addr_t bc);
        coeff_t edge_a [3];
        coeff_t edge_b [3];
        coeff_t ca;
        coeff_t cb;
        int     sel;
        edge_a = '{QM1, '0, '0};
        edge_b = '{QM1, QM1, coeff_t'(1)};
        for (int k = 0; k < `PWO_WORDS; k++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                ca  = rand_coeff();
                cb  = rand_coeff();
                sel = (k + l) % 4;
                if (edge_pairs && sel < 3) begin
                    ca = edge_a[sel];
                    cb = edge_b[sel];
                end
                mem_a[addr_t'(ba + k)][l*`PWO_LANE_W +: `PWO_LANE_W] <= {1'b0, ca};
                mem_b[addr_t'(bb + k)][l*`PWO_LANE_W +: `PWO_LANE_W] <= {1'b0, cb};
                mem_c[addr_t'(bc + k)][l*`PWO_LANE_W +: `PWO_LANE_W] <= {1'b0, rand_coeff()};
            end
        end
    endtask

    task automatic run_op(input pwo_mode_e m, input bit acc, input addr_t ba, input addr_t bb,
                          input addr_t bc, input int stall_pct, input bit flip_acc,
                          input bit restart, input int zeroize_at);
        int cyc_n;
        int last_wr;
        bit seen_done;
        cyc_n     = 0;
        last_wr   = -10;
        seen_done = 0;
        @(posedge clk);
        #2;
        mode          = m;
        accumulate    = acc;
        base_a        = ba;
        base_b        = bb;
        base_c        = bc;
        sampler_valid = 1'b1;
        pwo_enable    = 1'b1;
        arm           = 1'b1;
        @(posedge clk);
        #1;
        if (busy !== 1'b1) flag("busy did not rise after start");
        #1;
        arm = 1'b0;
        if (flip_acc) accumulate = !acc;
        if (restart) begin
            // Second start while busy, must be ignored
            mode   = PWO_PWS;
            base_c = bc + 15'd100;
        end else begin
            pwo_enable = 1'b0;
        end
        while (!seen_done) begin
            sampler_valid = ($urandom % 100) >= stall_pct;
            zeroize       = (zeroize_at > 0) && (cyc_n + 1 == zeroize_at);
            @(posedge clk);
            #1;
            cyc_n++;
            pwo_enable = 1'b0;
            if (zeroize) begin
                if (busy || done || rd_en_a || rd_en_b || rd_en_c || wr_en)
                    flag("outputs still active after zeroize");
                #1;
                zeroize = 1'b0;
                repeat (10) begin
                    @(posedge clk);
                    #1;
                    if (wr_en || busy) flag("activity after zeroize");
                end
                return;
            end
            if (wr_en) last_wr = cyc_n;
            if (done) begin
                seen_done = 1;
                if (last_wr != cyc_n - 1) flag("done not in the cycle after the last write");
                if (busy) flag("busy still high with done");
            end else if (cyc_n > 2000) begin
                $display("Run never signalled done after %0d cycles", cyc_n);
                tb_err++;
                return;
            end
            #1;
        end
        @(posedge clk);
        #1;
        if (done) flag("done longer than one cycle");
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        int errs;
        errs = total_errs() - errs_before;
        if (errs == 0) tests_ok++;
        else tests_bad++;
        $display("Test %0d %s: %s (%0d errors)", num, name, errs == 0 ? "ok" : "bad", errs);
    endtask

    initial begin
        void'($urandom(32'hd49b_c50e));
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        pwo_enable    = 1'b0;
        accumulate    = 1'b0;
        sampler_valid = 1'b0;
        arm           = 1'b0;
        mode          = PWO_PWM;
        base_a        = '0;
        base_b        = '0;
        base_c        = '0;
        rd_data_a     = '0;
        rd_data_b     = '0;
        rd_data_c     = '0;
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        e0 = total_errs();
        fill_region(0, 15'h0100, 15'h0200, 15'h0300);
        run_op(PWO_PWM, 0, 15'h0100, 15'h0200, 15'h0300, 0, 0, 0, 0);
        end_test(1, "pwm", e0);

        e0 = total_errs();
        fill_region(0, 15'h0400, 15'h0500, 15'h0600);
        run_op(PWO_PWM, 1, 15'h0400, 15'h0500, 15'h0600, 0, 0, 0, 0);
        end_test(2, "pwm accumulate", e0);

        e0 = total_errs();
        fill_region(1, 15'h0700, 15'h0800, 15'h0900);
        run_op(PWO_PWA, 0, 15'h0700, 15'h0800, 15'h0900, 0, 0, 0, 0);
        fill_region(1, 15'h0700, 15'h0800, 15'h0900);
        run_op(PWO_PWS, 0, 15'h0700, 15'h0800, 15'h0900, 0, 0, 0, 0);
        end_test(3, "pwa and pws", e0);

        // Result block wraps past the top of the address space
        e0 = total_errs();
        fill_region(0, 15'h1000, 15'h2000, 15'h7ff0);
        run_op(PWO_PWM, 1, 15'h1000, 15'h2000, 15'h7ff0, 40, 1, 0, 0);
        end_test(4, "sampler stalls", e0);

        e0 = total_errs();
        fill_region(0, 15'h3000, 15'h3100, 15'h3200);
        run_op(PWO_PWA, 0, 15'h3000, 15'h3100, 15'h3200, 10, 0, 1, 0);
        end_test(5, "start and end protocol", e0);

        e0 = total_errs();
        fill_region(0, 15'h4000, 15'h4100, 15'h4200);
        run_op(PWO_PWM, 1, 15'h4000, 15'h4100, 15'h4200, 0, 0, 0, 20);
        fill_region(0, 15'h4000, 15'h4100, 15'h4200);
        run_op(PWO_PWM, 1, 15'h4000, 15'h4100, 15'h4200, 20, 0, 0, 0);
        end_test(6, "zeroize", e0);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errs());
        if (total_errs() == 0 && tests_bad == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pwo_top.f ====
+incdir+source
source/pwo_pkg.sv
source/pwo_cfg_regs.sv
source/pwo_ctrl.sv
source/pwo_lane.sv
source/pwo_datapath.sv
source/pwo_top.sv
dv/pwo_checker.sv
dv/pwo_assert.sv
dv/pwo_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := pwo_tb
FILELIST  := pwo_top.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
